// ==== vlog.f ====
hw/axi_iso_pkg.sv
hw/axi_iso_fsm.sv
hw/axi_iso_wdata_align.sv
hw/axi_iso_resp_tracker.sv
hw/axi_iso_sub.sv
dv/tb_clk_gen.sv
dv/axi_iso_checker.sv
dv/tb_axi_iso_sub.sv

// ==== run.sh ====
#!/bin/sh
# Compile with Verilator, run, and decide the result from the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_axi_iso_sub -f vlog.f -o sim_tb
if [ $? -ne 0 ]; then
  echo "Compile failed"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Result: FAILED" sim.log; then
  exit 1
fi
if ! grep -q "Result: PASSED" sim.log; then
  echo "No result line in the log"
  exit 1
fi
exit 0

// ==== dv/tb_axi_iso_sub.sv ====
// Testbench with stimulus, subordinate model, reference response, compare, watchdog and report
`timescale 1ns/1ps

module tb_axi_iso_sub;

  import axi_iso_pkg::*;

  localparam int CLK_PERIOD_NS = 10;
  localparam int WAIT_CYCLES   = 400;
  // Writes issued over all five tests
  localparam int NUM_WRITES    = 12 + 4 + 6 + 6 + MAX_OUTSTANDING + 1;
  // Worst case for one AW and up to four W beats under random stalls
  localparam int WRITE_CYCLES  = 40;
  // Five drain waits and two waits on isolate_done
  localparam int NUM_WAITS     = 7;
  // Plus the test 5 stall window and reset
  localparam int WORST_CYCLES  = NUM_WRITES * WRITE_CYCLES + NUM_WAITS * WAIT_CYCLES + 16 + 4;

  // Fixed AW attributes, 4-byte beats in INCR bursts
  localparam logic [SIZE_W-1:0]  AW_SIZE  = 3'd2;
  localparam logic [BURST_W-1:0] AW_BURST = 2'b01;

  logic clk, arst_n, isolate_req, isolate_done;
  logic [ADDR_W-1:0] up_awaddr, dn_awaddr;
  logic [LEN_W-1:0] up_awlen, dn_awlen;
  logic [SIZE_W-1:0] up_awsize, dn_awsize;
  logic [BURST_W-1:0] up_awburst, dn_awburst;
  logic [PROT_W-1:0] up_awprot, dn_awprot;
  logic up_awvalid, up_awready, dn_awvalid, dn_awready;
  logic [DATA_W-1:0] up_wdata, dn_wdata;
  logic [STRB_W-1:0] up_wstrb, dn_wstrb;
  logic up_wlast, up_wvalid, up_wready, dn_wlast, dn_wvalid, dn_wready;
  logic [RESP_W-1:0] up_bresp, dn_bresp;
  logic up_bvalid, up_bready, dn_bvalid, dn_bready;

  // Scoreboard state
  logic [31:0] lfsr_q = 32'h35c6_dabb;
  logic [31:0] cur_addr, cur_len, cur_prot, cur_data, cur_strb, cur_last;
  int  err_cnt = 0;
  int  wr_cnt = 0;
  int  wr_issued = 0;
  int  b_cnt = 0;
  int  dn_pend = 0;
  int  dn_idx_q[$];
  bit  ok_flag [0:255];
  bit  b_stall = 0;
  bit  bready_hold = 0;
  bit  b_taken = 0;
  int  e0;

  tb_clk_gen #(.PERIOD_NS(CLK_PERIOD_NS)) u_clk (.clk(clk));

  axi_iso_sub DUT (.*);

  // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  // OKAY only if the subordinate answered while connected
  function automatic logic [RESP_W-1:0] expect_bresp(input int idx);
    return ok_flag[idx] ? RESP_OKAY : ISOLATE_RESP;
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (exp === act) else begin
      $display("[FAIL] %0t ns %s expected %h actual %h", $time, name, exp, act);
      err_cnt++;
    end
  endtask

  // One burst with AW first and then one to four W beats
  task automatic do_write();
    logic [31:0] r;
    int len;
    @(negedge clk);
    r = rand_bits(17);
    len = int'(r[13:12]);
    up_awaddr = r[ADDR_W-1:0];
    up_awlen = LEN_W'(len);
    up_awprot = r[16:14];
    cur_addr = 32'(r[ADDR_W-1:0]);
    cur_len = 32'(len);
    cur_prot = 32'(r[16:14]);
    up_awvalid = 1'b1;
    #1;
    while (!up_awready) begin
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    up_awvalid = 1'b0;
    for (int b = 0; b <= len; b++) begin
      r = rand_bits(32);
      up_wdata = r;
      cur_data = r;
      r = rand_bits(STRB_W);
      up_wstrb = r[STRB_W-1:0];
      cur_strb = 32'(r[STRB_W-1:0]);
      up_wlast = (b == len);
      cur_last = 32'(b == len);
      up_wvalid = 1'b1;
      #1;
      while (!up_wready) begin
        @(negedge clk);
        #1;
      end
      @(negedge clk);
    end
    up_wvalid = 1'b0;
    up_wlast = 1'b0;
    wr_issued++;
  endtask

  // All accepted writes answered and the subordinate empty
  task automatic wait_quiet();
    int n;
    n = 0;
    while (!(b_cnt == wr_cnt && dn_pend == 0 && !dn_bvalid) && n < WAIT_CYCLES) begin
      @(negedge clk);
      n++;
    end
    if (n >= WAIT_CYCLES) begin
      $display("Timed out waiting for write responses to drain");
      err_cnt++;
    end
  endtask

  task automatic wait_done(input logic level);
    int n;
    n = 0;
    while (isolate_done !== level && n < WAIT_CYCLES) begin
      @(negedge clk);
      n++;
    end
    if (n >= WAIT_CYCLES) begin
      $display("Timed out waiting for isolate_done to reach %0b", level);
      err_cnt++;
    end
  endtask

  task automatic report(input string name, input int base);
    $display("Test %s: %0d errors", name, err_cnt - base);
  endtask

  // Subordinate model and upstream bready driven on the falling edge
  initial begin
    logic [31:0] r;
    dn_awready = 1'b0;
    dn_wready = 1'b0;
    dn_bvalid = 1'b0;
    dn_bresp = RESP_OKAY;
    up_bready = 1'b0;
    forever begin
      @(negedge clk);
      if (b_taken) begin
        dn_bvalid = 1'b0;
        b_taken = 1'b0;
      end
      r = rand_bits(8);
      dn_awready = r[0] | r[1];
      dn_wready = r[2] | r[3];
      // Answer each completed burst after a random stall
      if (!dn_bvalid && dn_pend > 0 && !b_stall && (r[4] | r[5])) begin
        dn_bvalid = 1'b1;
        dn_bresp = RESP_OKAY;
      end
      up_bready = bready_hold ? 1'b0 : (r[6] | r[7]);
    end
  end

  // Handshake monitor sampling mid-cycle where everything has settled
  initial begin
    forever begin
      @(negedge clk);
      #2;
      if (arst_n) begin
        if (dn_awvalid && dn_awready) begin
          check_val("dn_awaddr", cur_addr, 32'(dn_awaddr));
          check_val("dn_awlen", cur_len, 32'(dn_awlen));
          check_val("dn_awsize", 32'(AW_SIZE), 32'(dn_awsize));
          check_val("dn_awburst", 32'(AW_BURST), 32'(dn_awburst));
          check_val("dn_awprot", cur_prot, 32'(dn_awprot));
          dn_idx_q.push_back(wr_cnt);
        end
        if (dn_wvalid && dn_wready) begin
          check_val("dn_wdata", cur_data, dn_wdata);
          check_val("dn_wstrb", cur_strb, 32'(dn_wstrb));
          check_val("dn_wlast", cur_last, 32'(dn_wlast));
          if (dn_wlast) begin
            dn_pend++;
          end
        end
        // Downstream B first since a passed-through B lands in the same cycle
        if (dn_bvalid && dn_bready) begin
          if (dn_idx_q.size() == 0) begin
            $display("Downstream response taken with no write sent downstream");
            err_cnt++;
          end else begin
            ok_flag[dn_idx_q.pop_front()] = !isolate_done;
          end
          dn_pend--;
          b_taken = 1'b1;
        end
        if (up_bvalid && up_bready) begin
          if (b_cnt >= wr_cnt) begin
            $display("Upstream response with no write outstanding");
            err_cnt++;
          end else begin
            check_val("up_bresp", 32'(expect_bresp(b_cnt)), 32'(up_bresp));
          end
          b_cnt++;
        end
        if (up_awvalid && up_awready) begin
          wr_cnt++;
        end
      end
    end
  end

  // Watchdog
  initial begin
    #(WORST_CYCLES * 4 * CLK_PERIOD_NS);
    $display("Watchdog expired, the run did not finish in time");
    $display("Result: FAILED");
    $finish;
  end

  initial begin
    arst_n = 1'b0;
    isolate_req = 1'b0;
    up_awaddr = '0;
    up_awlen = '0;
    up_awsize = AW_SIZE;
    up_awburst = AW_BURST;
    up_awprot = '0;
    up_awvalid = 1'b0;
    up_wdata = '0;
    up_wstrb = '0;
    up_wlast = 1'b0;
    up_wvalid = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;

    e0 = err_cnt;
    repeat (12) do_write();
    wait_quiet();
    report("1 pass-through", e0);

    // Stale writes left unanswered before isolation
    e0 = err_cnt;
    b_stall = 1'b1;
    repeat (4) do_write();
    @(negedge clk);
    isolate_req = 1'b1;
    wait_done(1'b1);
    b_stall = 1'b0;
    wait_quiet();
    report("2 isolation with pending writes", e0);

    e0 = err_cnt;
    repeat (6) do_write();
    wait_quiet();
    report("3 isolated traffic", e0);

    e0 = err_cnt;
    @(negedge clk);
    isolate_req = 1'b0;
    wait_done(1'b0);
    repeat (6) do_write();
    wait_quiet();
    report("4 reconnect", e0);

    // Fill the tracker with upstream B stalled so the next AW must wait
    e0 = err_cnt;
    bready_hold = 1'b1;
    repeat (MAX_OUTSTANDING) do_write();
    fork
      do_write();
    join_none
    repeat (16) begin
      @(negedge clk);
      #3;
      check_val("up_awready", 32'd0, 32'(up_awready));
    end
    bready_hold = 1'b0;
    wait fork;
    wait_quiet();
    check_val("b_count", 32'(wr_issued), 32'(b_cnt));
    report("5 back-pressure", e0);

    $display("Writes %0d, responses %0d, errors %0d", wr_cnt, b_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// ==== dv/axi_iso_checker.sv ====
// Bound assertions on handshake stability, isolation gating and reset values
`timescale 1ns/1ps

module axi_iso_checker (
  input logic                            clk,
  input logic                            arst_n,
  input logic                            isolate_done,
  input logic                            up_bvalid,
  input logic                            up_bready,
  input logic [axi_iso_pkg::RESP_W-1:0]  up_bresp,
  input logic                            dn_awvalid,
  input logic                            dn_awready,
  input logic [axi_iso_pkg::ADDR_W-1:0]  dn_awaddr,
  input logic [axi_iso_pkg::LEN_W-1:0]   dn_awlen,
  input logic                            dn_wvalid,
  input logic                            dn_wready,
  input logic [axi_iso_pkg::DATA_W-1:0]  dn_wdata,
  input logic                            dn_wlast
);

  // Upstream B held until taken, including generated responses
  b_stable: assert property (@(posedge clk) disable iff (!arst_n)
    up_bvalid && !up_bready |=> up_bvalid && $stable(up_bresp))
    else $error("upstream B changed before handshake");

  // Downstream AW never withdrawn or altered
  aw_stable: assert property (@(posedge clk) disable iff (!arst_n)
    dn_awvalid && !dn_awready |=> dn_awvalid && $stable(dn_awaddr) && $stable(dn_awlen))
    else $error("downstream AW changed before handshake");

  // Same for downstream W
  w_stable: assert property (@(posedge clk) disable iff (!arst_n)
    dn_wvalid && !dn_wready |=> dn_wvalid && $stable(dn_wdata) && $stable(dn_wlast))
    else $error("downstream W changed before handshake");

  // Subordinate sees nothing while isolated
  iso_quiet: assert property (@(posedge clk) disable iff (!arst_n)
    isolate_done |-> !dn_awvalid && !dn_wvalid)
    else $error("downstream valid raised while isolated");

  // No response offered while in reset
  b_reset_low: assert property (@(posedge clk) !arst_n |-> !up_bvalid)
    else $error("upstream bvalid high during reset");

endmodule

bind axi_iso_sub axi_iso_checker u_checker (.*);

// ==== dv/tb_clk_gen.sv ====
// Free-running testbench clock source
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD_NS = 10
) (
  output logic clk
);

  // Starts low so the first rising edge lands at half a period
  initial begin
    clk = 1'b0;
    forever begin
      #(PERIOD_NS / 2);
      clk = ~clk;
    end
  end

endmodule

// ==== hw/axi_iso_sub.sv ====
// Top level of the AXI4 write-channel subordinate isolator
`timescale 1ns/1ps

module axi_iso_sub (
  input  logic                             clk,
  input  logic                             arst_n,
  input  logic                             isolate_req,
  output logic                             isolate_done,
  // Upstream manager side
  input  logic [axi_iso_pkg::ADDR_W-1:0]   up_awaddr,
  input  logic [axi_iso_pkg::LEN_W-1:0]    up_awlen,
  input  logic [axi_iso_pkg::SIZE_W-1:0]   up_awsize,
  input  logic [axi_iso_pkg::BURST_W-1:0]  up_awburst,
  input  logic [axi_iso_pkg::PROT_W-1:0]   up_awprot,
  input  logic                             up_awvalid,
  output logic                             up_awready,
  input  logic [axi_iso_pkg::DATA_W-1:0]   up_wdata,
  input  logic [axi_iso_pkg::STRB_W-1:0]   up_wstrb,
  input  logic                             up_wlast,
  input  logic                             up_wvalid,
  output logic                             up_wready,
  output logic [axi_iso_pkg::RESP_W-1:0]   up_bresp,
  output logic                             up_bvalid,
  input  logic                             up_bready,
  // Downstream subordinate side
  output logic [axi_iso_pkg::ADDR_W-1:0]   dn_awaddr,
  output logic [axi_iso_pkg::LEN_W-1:0]    dn_awlen,
  output logic [axi_iso_pkg::SIZE_W-1:0]   dn_awsize,
  output logic [axi_iso_pkg::BURST_W-1:0]  dn_awburst,
  output logic [axi_iso_pkg::PROT_W-1:0]   dn_awprot,
  output logic                             dn_awvalid,
  input  logic                             dn_awready,
  output logic [axi_iso_pkg::DATA_W-1:0]   dn_wdata,
  output logic [axi_iso_pkg::STRB_W-1:0]   dn_wstrb,
  output logic                             dn_wlast,
  output logic                             dn_wvalid,
  input  logic                             dn_wready,
  input  logic [axi_iso_pkg::RESP_W-1:0]   dn_bresp,
  input  logic                             dn_bvalid,
  output logic                             dn_bready
);

  logic hold_req;
  logic hold_done;
  logic iso_active;
  logic trk_push_valid;
  logic trk_push_ready;
  logic resp_empty;

  // Sequencing of hold, isolation and reconnect
  axi_iso_fsm u_fsm (
    .clk          (clk),
    .arst_n       (arst_n),
    .isolate_req  (isolate_req),
    .hold_done    (hold_done),
    .resp_empty   (resp_empty),
    .isolate_done (isolate_done),
    .hold_req     (hold_req),
    .iso_active   (iso_active)
  );

  // Handshake control for AW and W, payload bypasses it
  axi_iso_wdata_align u_align (
    .clk            (clk),
    .arst_n         (arst_n),
    .hold_req       (hold_req),
    .iso_active     (iso_active),
    .up_awvalid     (up_awvalid),
    .up_awlen       (up_awlen),
    .up_wvalid      (up_wvalid),
    .up_wlast       (up_wlast),
    .dn_awready     (dn_awready),
    .dn_wready      (dn_wready),
    .trk_push_ready (trk_push_ready),
    .hold_done      (hold_done),
    .up_awready     (up_awready),
    .up_wready      (up_wready),
    .dn_awvalid     (dn_awvalid),
    .dn_wvalid      (dn_wvalid),
    .trk_push_valid (trk_push_valid)
  );

  // One entry per accepted AW, retired by the upstream B
  axi_iso_resp_tracker u_tracker (
    .clk        (clk),
    .arst_n     (arst_n),
    .iso_active (iso_active),
    .push_valid (trk_push_valid),
    .push_ready (trk_push_ready),
    .resp_empty (resp_empty),
    .dn_bvalid  (dn_bvalid),
    .dn_bresp   (dn_bresp),
    .dn_bready  (dn_bready),
    .up_bvalid  (up_bvalid),
    .up_bresp   (up_bresp),
    .up_bready  (up_bready)
  );

  // AW payload straight through, only valid is gated
  assign dn_awaddr  = up_awaddr;
  assign dn_awlen   = up_awlen;
  assign dn_awsize  = up_awsize;
  assign dn_awburst = up_awburst;
  assign dn_awprot  = up_awprot;

  // W payload straight through
  assign dn_wdata = up_wdata;
  assign dn_wstrb = up_wstrb;
  assign dn_wlast = up_wlast;

endmodule

// ==== hw/axi_iso_resp_tracker.sv ====
// Outstanding write counter, B pass-through and generated isolation responses
`timescale 1ns/1ps

module axi_iso_resp_tracker (
  input  logic                            clk,
  input  logic                            arst_n,
  input  logic                            iso_active,
  input  logic                            push_valid,
  output logic                            push_ready,
  output logic                            resp_empty,
  input  logic                            dn_bvalid,
  input  logic [axi_iso_pkg::RESP_W-1:0]  dn_bresp,
  output logic                            dn_bready,
  output logic                            up_bvalid,
  output logic [axi_iso_pkg::RESP_W-1:0]  up_bresp,
  input  logic                            up_bready
);

  import axi_iso_pkg::*;

  logic [CNT_W-1:0] count_q;
  logic [CNT_W-1:0] count_d;
  logic             push_fire;
  logic             pop_fire;
  logic             gen_mode_q;
  logic             gen_mode_d;
  logic             gen_sel;
  logic             gen_valid_q;

  // Single ID, so responses come back in order and a count is enough
  assign push_ready = count_q != CNT_W'(MAX_OUTSTANDING);
  assign push_fire  = push_valid && push_ready;
  assign pop_fire   = up_bvalid && up_bready;

  always_comb begin
    count_d = count_q;
    if (push_fire && !pop_fire) begin
      count_d = count_q + CNT_W'(1);
    end else if (pop_fire && !push_fire) begin
      count_d = count_q - CNT_W'(1);
    end
  end

  // Switch to generated responses once no passed-through B is waiting
  // upstream, so an offered response is never pulled back or changed
  assign gen_mode_d = iso_active && (gen_mode_q || !dn_bvalid || up_bready);
  assign gen_sel    = gen_mode_q && iso_active;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      count_q     <= '0;
      gen_mode_q  <= 1'b0;
      gen_valid_q <= 1'b0;
    end else begin
      count_q    <= count_d;
      gen_mode_q <= gen_mode_d;
      // Stays up while unaccepted, since the count cannot drop then
      gen_valid_q <= gen_mode_d && (count_d != '0);
    end
  end

  // Upstream B mux
  always_comb begin
    if (gen_sel) begin
      up_bvalid = gen_valid_q;
      up_bresp  = ISOLATE_RESP;
      // Stale downstream responses are drained and dropped
      dn_bready = 1'b1;
    end else begin
      up_bvalid = dn_bvalid;
      up_bresp  = dn_bresp;
      dn_bready = up_bready;
    end
  end

  // Every accepted write has had its B
  assign resp_empty = count_q == '0;

endmodule

// ==== hw/axi_iso_wdata_align.sv ====
// AW/W beat accounting, hold-off, AW fork to subordinate and tracker, downstream gating
`timescale 1ns/1ps

module axi_iso_wdata_align (
  input  logic                           clk,
  input  logic                           arst_n,
  input  logic                           hold_req,
  input  logic                           iso_active,
  input  logic                           up_awvalid,
  input  logic [axi_iso_pkg::LEN_W-1:0]  up_awlen,
  input  logic                           up_wvalid,
  input  logic                           up_wlast,
  input  logic                           dn_awready,
  input  logic                           dn_wready,
  input  logic                           trk_push_ready,
  output logic                           hold_done,
  output logic                           up_awready,
  output logic                           up_wready,
  output logic                           dn_awvalid,
  output logic                           dn_wvalid,
  output logic                           trk_push_valid
);

  import axi_iso_pkg::*;

  // Positive means W beats still owed to accepted AWs
  // Negative means W has run ahead of AW
  logic signed [BEAT_CNT_W-1:0] balance_q;
  logic signed [BEAT_CNT_W-1:0] balance_d;
  logic signed [BEAT_CNT_W-1:0] aw_beats;
  logic signed [BEAT_CNT_W-1:0] aw_add;
  logic signed [BEAT_CNT_W-1:0] w_sub;
  logic signed [BEAT_CNT_W-1:0] skew_lim;

  logic dn_awready_eff;
  logic dn_wready_eff;
  logic aw_open;
  logic w_open;
  logic aw_offer;
  logic aw_fire;
  logic w_fire;
  logic aw_stall_q;
  logic w_stall_q;
  logic w_in_burst_q;

  assign skew_lim = BEAT_CNT_W'(MAX_SKEW_BEATS);
  assign aw_beats = BEAT_CNT_W'(up_awlen) + BEAT_CNT_W'(1);

  // Isolated side looks always ready so writes are swallowed
  assign dn_awready_eff = dn_awready || iso_active;
  assign dn_wready_eff  = dn_wready || iso_active;

  // AW gate
  // Normal: cap how far AW runs ahead
  // Hold: AW only to catch up with W that already went ahead
  // A stalled AW stays open so the valid is never withdrawn
  always_comb begin
    if (aw_stall_q) begin
      aw_open = 1'b1;
    end else if (hold_req) begin
      aw_open = balance_q < 0;
    end else begin
      aw_open = balance_q < skew_lim;
    end
  end

  // W gate, mirror of the AW gate
  // Hold lets W run only while beats are owed
  always_comb begin
    if (w_stall_q) begin
      w_open = 1'b1;
    end else if (hold_req) begin
      w_open = balance_q > 0;
    end else begin
      w_open = balance_q > -skew_lim;
    end
  end

  // AW fork, nothing is consumed until both sides can take it
  assign aw_offer       = up_awvalid && aw_open;
  assign dn_awvalid     = aw_offer && trk_push_ready && !iso_active;
  assign trk_push_valid = aw_offer && dn_awready_eff;
  assign up_awready     = aw_open && trk_push_ready && dn_awready_eff;
  assign aw_fire        = aw_offer && trk_push_ready && dn_awready_eff;

  // W path
  assign dn_wvalid = up_wvalid && w_open && !iso_active;
  assign up_wready = w_open && dn_wready_eff;
  assign w_fire    = up_wvalid && up_wready;

  // Beat balance update
  assign aw_add    = aw_fire ? aw_beats : '0;
  assign w_sub     = w_fire ? BEAT_CNT_W'(1) : '0;
  assign balance_d = balance_q + aw_add - w_sub;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      balance_q    <= '0;
      w_in_burst_q <= 1'b0;
      aw_stall_q   <= 1'b0;
      w_stall_q    <= 1'b0;
    end else begin
      balance_q <= balance_d;
      if (w_fire) begin
        w_in_burst_q <= !up_wlast;
      end
      // Presented downstream but not taken yet
      aw_stall_q <= dn_awvalid && !dn_awready;
      w_stall_q  <= dn_wvalid && !dn_wready;
    end
  end

  // Aligned: no beat owed, no burst half sent, nothing left presented
  assign hold_done = hold_req && (balance_q == '0) && !w_in_burst_q &&
                     !aw_stall_q && !w_stall_q;

endmodule

// ==== hw/axi_iso_fsm.sv ====
// Isolation sequencing FSM: hold, isolate, drain and reconnect
`timescale 1ns/1ps

module axi_iso_fsm (
  input  logic clk,
  input  logic arst_n,
  input  logic isolate_req,
  input  logic hold_done,
  input  logic resp_empty,
  output logic isolate_done,
  output logic hold_req,
  output logic iso_active
);

  import axi_iso_pkg::*;

  logic [ST_W-1:0] state_q;
  logic [ST_W-1:0] state_d;
  logic            done_q;

  // Next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_CONNECTED: begin
        if (isolate_req) begin
          state_d = ST_HOLD;
        end
      end
      ST_HOLD: begin
        // Stay until AW and W line up on a burst boundary
        // A dropped request still goes through isolation and back
        if (hold_done) begin
          state_d = ST_ISOLATED;
        end
      end
      ST_ISOLATED: begin
        if (!isolate_req) begin
          state_d = ST_RECONNECT;
        end
      end
      ST_RECONNECT: begin
        // All generated responses gone and no W beat owed to a
        // discarded AW, otherwise the subordinate would see orphan data
        if (resp_empty && hold_done) begin
          state_d = ST_CONNECTED;
        end
      end
      default: begin
        state_d = ST_CONNECTED;
      end
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= ST_CONNECTED;
    end else begin
      state_q <= state_d;
    end
  end

  // Done follows the isolated states one cycle late
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      done_q <= 1'b0;
    end else begin
      done_q <= (state_q == ST_ISOLATED) || (state_q == ST_RECONNECT);
    end
  end

  assign isolate_done = done_q;

  // AW held off while lining up, and again while draining for reconnect
  assign hold_req = (state_q == ST_HOLD) || (state_q == ST_RECONNECT);

  // Downstream cut off from the end of hold until reconnection
  assign iso_active = (state_q == ST_ISOLATED) || (state_q == ST_RECONNECT);

endmodule

// ==== hw/axi_iso_pkg.sv ====
// Shared widths, limits, response codes and isolation FSM state codes
package axi_iso_pkg;

  // AXI field widths
  localparam int ADDR_W  = 12;
  localparam int DATA_W  = 32;
  localparam int STRB_W  = DATA_W / 8;
  localparam int LEN_W   = 8;
  localparam int RESP_W  = 2;
  localparam int SIZE_W  = 3;
  localparam int BURST_W = 2;
  localparam int PROT_W  = 3;

  // Writes tracked before AW is back-pressured
  localparam int MAX_OUTSTANDING = 8;
  // Must hold 0 up to MAX_OUTSTANDING inclusive
  localparam int CNT_W = $clog2(MAX_OUTSTANDING + 1);

  // W may run this many beats ahead of AW, two max-length bursts
  localparam int MAX_SKEW_BEATS = 512;
  // Signed balance, sized for the skew limit plus one max burst either way
  localparam int BEAT_CNT_W = 11;

  // Response codes
  localparam logic [RESP_W-1:0] RESP_OKAY   = 2'b00;
  localparam logic [RESP_W-1:0] RESP_SLVERR = 2'b10;
  // Response returned for writes that never reach the subordinate
  localparam logic [RESP_W-1:0] ISOLATE_RESP = RESP_SLVERR;

  // Isolation sequencing states
  localparam int ST_W = 2;
  localparam logic [ST_W-1:0] ST_CONNECTED = 2'd0;
  localparam logic [ST_W-1:0] ST_HOLD      = 2'd1;
  localparam logic [ST_W-1:0] ST_ISOLATED  = 2'd2;
  localparam logic [ST_W-1:0] ST_RECONNECT = 2'd3;

endpackage
